//--- all.f
+incdir+verilog
verilog/issue_pkg.sv
verilog/ingress_stage.sv
verilog/decode_stage.sv
verilog/hazard_scoreboard.sv
verilog/egress_stage.sv
verilog/issue_top.sv
bench/clk_gen.sv
bench/tb_issue.sv

//--- Bender.yml
package:
  name: issue_section

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/issue_pkg.sv
      - verilog/ingress_stage.sv
      - verilog/decode_stage.sv
      - verilog/hazard_scoreboard.sv
      - verilog/egress_stage.sv
      - verilog/issue_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/clk_gen.sv
      - bench/tb_issue.sv

//--- bench/tb_issue.sv
`timescale 1ns/1ps
`include "issue_cfg.svh"

module tb_issue import issue_pkg::*; ();

	localparam int n_instr    = 400;
	localparam int max_cycles = n_instr * 40;

	localparam logic [6:0] legal_ops [9] = '{7'b0110111, 7'b0010111, 7'b1101111,
		7'b1100111, 7'b1100011, 7'b0000011, 7'b0100011, 7'b0110011, 7'b0010011};

	logic        clk;
	logic        nrst;
	logic        in_req;
	instr_u      in_instr;
	logic        in_ack;
	logic        out_req;
	instr_u      out_instr;
	unit_class_e out_class;
	logic        out_illegal;
	logic        out_ack;
	logic        stall;

	integer      seed = 32'h58eb_c861;
	instr_u      exp_q [$];	// words sent and not yet seen at the output
	int          last_rise [`ISSUE_NREGS];	// cycle of the last out_req edge per register
	int          cycle = 0;
	int          sent_count = 0;
	int          recv_count = 0;
	int          mismatch_errs = 0;
	int          protocol_errs = 0;
	int          hazard_errs = 0;
	logic        prev_in_ack = 1'b0;
	logic        prev_out_req = 1'b0;
	instr_u      prev_instr;
	unit_class_e prev_class;
	logic        prev_illegal;

	clk_gen i_clk_gen (.clk, .nrst);

	issue_top i_dut (.clk, .nrst, .in_req, .in_instr, .in_ack, .out_req, .out_instr,
		.out_class, .out_illegal, .out_ack, .stall);

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// reference decode table
	function automatic unit_class_e model_class(input logic [6:0] op);
		case (op)
			7'b0110111, 7'b0010111, 7'b1101111: return uc_upper;
			7'b1100111: return uc_jalr;
			7'b1100011: return uc_branch;
			7'b0000011: return uc_load;
			7'b0100011: return uc_store;
			7'b0110011: return uc_alu_reg;
			7'b0010011: return uc_alu_imm;
			default:    return uc_none;
		endcase
	endfunction

	function automatic logic [2:0] model_use(input unit_class_e c);
		case (c)	// rd, rs1, rs2
			uc_upper:                     return 3'b100;
			uc_jalr, uc_load, uc_alu_imm: return 3'b110;
			uc_branch:                    return 3'b011;
			uc_store, uc_alu_reg:         return 3'b111;
			default:                      return 3'b000;
		endcase
	endfunction

	function automatic instr_u build_word();
		instr_u      w;
		int          k;
		logic [6:0]  op;
		unit_class_e c;
		k = pick(10);
		if (k < 9)
			op = legal_ops[k];
		else
		begin
			op = 7'(pick(128));
			while (model_class(op) != uc_none)
				op = op + 7'd1;	// step to the next unknown opcode
		end
		c = model_class(op);
		if (c == uc_jalr || c == uc_load || c == uc_alu_imm)
		begin
			w.i_view.imm12  = 12'(pick(4096));
			w.i_view.rs1    = 5'(pick(8));
			w.i_view.funct3 = 3'(pick(8));
			w.i_view.rd     = 5'(pick(8));
			w.i_view.opcode = op;
		end
		else
		begin
			w.r_view.funct7 = 7'(pick(128));
			w.r_view.rs2    = 5'(pick(8));	// x0..x7 keeps hazards frequent
			w.r_view.rs1    = 5'(pick(8));
			w.r_view.funct3 = 3'(pick(8));
			w.r_view.rd     = 5'(pick(8));
			w.r_view.opcode = op;
		end
		return w;
	endfunction

	task automatic send_word(input instr_u w);
		@(posedge clk);
		in_instr <= w;
		in_req   <= 1'b1;
		exp_q.push_back(w);
		sent_count++;
		do @(posedge clk); while (!in_ack);
		in_req <= 1'b0;
		do @(posedge clk); while (in_ack);	// four-phase return to zero
	endtask

	task automatic check_output();
		instr_u      ew;
		unit_class_e ec;
		logic [2:0]  um;
		logic [4:0]  regs [3];
		assert (sent_count > 0) else
		begin
			protocol_errs++;
			$display("out_req rose at %0t before any instruction was sent", $time);
		end
		assert (!out_ack) else
		begin
			protocol_errs++;
			$display("out_req rose at %0t while out_ack was still high", $time);
		end
		assert (exp_q.size() > 0) else
		begin
			protocol_errs++;
			$display("Unexpected extra output at %0t, word %h", $time, out_instr);
		end
		if (exp_q.size() == 0)
			return;
		ew = exp_q.pop_front();
		ec = model_class(ew.r_view.opcode);
		um = model_use(ec);
		recv_count++;
		assert (out_instr == ew) else
		begin
			mismatch_errs++;
			$display("Mismatch at %0t: output %0d word %h, expected %h", $time, recv_count,
				out_instr, ew);
		end
		assert (out_class == ec && out_illegal == (ec == uc_none)) else
		begin
			mismatch_errs++;
			$display("Mismatch at %0t: output %0d class %s illegal %b, expected %s %b", $time,
				recv_count, out_class.name(), out_illegal, ec.name(), ec == uc_none);
		end
		regs[0] = ew.r_view.rd;
		regs[1] = ew.r_view.rs1;
		regs[2] = ew.r_view.rs2;
		for (int i = 0; i < 3; i++)
			if (um[2-i] && regs[i] != 5'd0 && last_rise[regs[i]] >= 0)
				assert (cycle - last_rise[regs[i]] > `ISSUE_BUSY_CYCLES) else	// free after countdown
				begin
					hazard_errs++;
					$display("Hazard violation at %0t: x%0d reused after %0d cycles", $time,
						regs[i], cycle - last_rise[regs[i]]);
				end
		for (int i = 0; i < 3; i++)
			if (um[2-i] && regs[i] != 5'd0)
				last_rise[regs[i]] = cycle;
	endtask

	// sink with a random ack delay
	initial
	begin
		int delay;
		forever
		begin
			@(posedge clk);
			if (out_req && !out_ack)
			begin
				delay = pick(5);
				repeat (delay) @(posedge clk);
				out_ack <= 1'b1;
				do @(posedge clk); while (out_req);
				out_ack <= 1'b0;
			end
		end
	end

	// monitor on the falling edge, away from the driving edge
	always @(negedge clk)
	begin
		if (nrst)
		begin
			cycle++;
			if (in_ack && !prev_in_ack)
				assert (in_req) else
				begin
					protocol_errs++;
					$display("in_ack rose at %0t while in_req was low", $time);
				end
			if (!in_ack && prev_in_ack)
				assert (!in_req) else
				begin
					protocol_errs++;
					$display("in_ack fell at %0t while in_req was still high", $time);
				end
			if (prev_out_req && out_req)
				assert (out_instr == prev_instr && out_class == prev_class &&
					out_illegal == prev_illegal) else
				begin
					mismatch_errs++;
					$display("Mismatch at %0t: output data changed while out_req high", $time);
				end
			if (prev_out_req && !out_req)
				assert (out_ack) else
				begin
					protocol_errs++;
					$display("out_req fell at %0t without out_ack", $time);
				end
			if (stall)
				assert (exp_q.size() > 0) else	// only a waiting instruction stalls
				begin
					protocol_errs++;
					$display("stall high at %0t with no instruction in flight", $time);
				end
			if (out_req && !prev_out_req)
				check_output();
		end
		prev_in_ack  = in_ack;
		prev_out_req = out_req;
		prev_instr   = out_instr;
		prev_class   = out_class;
		prev_illegal = out_illegal;
	end

	initial
	begin
		instr_u w;
		int     gap;
		int     total;
		in_req   = 1'b0;
		in_instr = '0;
		out_ack  = 1'b0;
		for (int r = 0; r < `ISSUE_NREGS; r++)
			last_rise[r] = -1;
		wait (nrst);
		@(negedge clk);
		assert (!in_ack && !out_req && !stall) else
		begin
			protocol_errs++;
			$display("in_ack, out_req or stall not low right after reset");
		end
		for (int n = 0; n < n_instr; n++)
		begin
			w   = build_word();
			gap = pick(3);
			repeat (gap) @(posedge clk);
			send_word(w);
		end
		wait (recv_count == n_instr);
		repeat (20) @(posedge clk);	// room for a duplicate to show up
		total = mismatch_errs + protocol_errs + hazard_errs;
		$display("sent %0d, received %0d, mismatches %0d, protocol errors %0d, hazard errors %0d",
			sent_count, recv_count, mismatch_errs, protocol_errs, hazard_errs);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		repeat (max_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d outputs seen", max_cycles,
			recv_count, n_instr);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int half_period  = 50,	// ns, gives a 100 ns clock
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial
	begin
		nrst = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		nrst <= 1'b1;	// released on a rising edge
	end

endmodule

//--- verilog/issue_top.sv
`timescale 1ns/1ps

module issue_top import issue_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic        in_req,
	input  instr_u      in_instr,
	output logic        in_ack,
	output logic        out_req,
	output instr_u      out_instr,
	output unit_class_e out_class,
	output logic        out_illegal,
	input  logic        out_ack,
	output logic        stall
);

	// ingress to decode
	logic        dec_valid;
	instr_u      dec_instr;
	logic        dec_ready;

	// decode to scoreboard
	logic        sb_valid;
	instr_u      sb_instr;
	unit_class_e sb_class;
	reg_use_t    sb_use;
	logic        sb_illegal;
	logic        sb_ready;

	// scoreboard to egress
	logic        iss_valid;
	instr_u      iss_instr;
	unit_class_e iss_class;
	logic        iss_illegal;
	logic        iss_ready;

	ingress_stage i_ingress (.clk, .nrst, .in_req, .in_instr, .in_ack,
		.dec_valid, .dec_instr, .dec_ready);

	decode_stage i_decode (.clk, .nrst, .dec_valid, .dec_instr, .dec_ready,
		.sb_valid, .sb_instr, .sb_class, .sb_use, .sb_illegal, .sb_ready);

	hazard_scoreboard i_scoreboard (.clk, .nrst, .sb_valid, .sb_instr, .sb_class,
		.sb_use, .sb_illegal, .sb_ready, .stall, .iss_valid, .iss_instr,
		.iss_class, .iss_illegal, .iss_ready);

	egress_stage i_egress (.clk, .nrst, .iss_valid, .iss_instr, .iss_class,
		.iss_illegal, .iss_ready, .out_req, .out_instr, .out_class,
		.out_illegal, .out_ack);

endmodule

//--- verilog/egress_stage.sv
`timescale 1ns/1ps

module egress_stage import issue_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic        iss_valid,
	input  instr_u      iss_instr,
	input  unit_class_e iss_class,
	input  logic        iss_illegal,
	output logic        iss_ready,
	output logic        out_req,
	output instr_u      out_instr,
	output unit_class_e out_class,
	output logic        out_illegal,
	input  logic        out_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_ack_drop
	} egr_state_e;

	egr_state_e state;

	assign iss_ready = (state == st_idle);	// only after ack has fallen
	assign out_req   = (state == st_req);

	always_ff @(posedge clk)
	begin
		if (!nrst)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:     if (iss_valid) state <= st_req;
				st_req:      if (out_ack) state <= st_ack_drop;
				st_ack_drop: if (!out_ack) state <= st_idle;	// four-phase done
				default:     state <= st_idle;
			endcase
		end
	end

	// output data register
	always_ff @(posedge clk)
	begin
		if (iss_valid && iss_ready)
		begin
			out_instr   <= iss_instr;
			out_class   <= iss_class;
			out_illegal <= iss_illegal;
		end
	end

	a_data_stable: assert property (@(posedge clk) disable iff (!nrst)
		(out_req && $past(out_req)) |->
		$stable({out_instr, out_class, out_illegal}));

endmodule

//--- verilog/hazard_scoreboard.sv
`timescale 1ns/1ps
`include "issue_cfg.svh"

module hazard_scoreboard import issue_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic        sb_valid,
	input  instr_u      sb_instr,
	input  unit_class_e sb_class,
	input  reg_use_t    sb_use,
	input  logic        sb_illegal,
	output logic        sb_ready,
	output logic        stall,
	output logic        iss_valid,
	output instr_u      iss_instr,
	output unit_class_e iss_class,
	output logic        iss_illegal,
	input  logic        iss_ready
);

	localparam logic [`ISSUE_CNT_W-1:0] busy_load = `ISSUE_BUSY_CYCLES;

	logic [`ISSUE_CNT_W-1:0] cnt [`ISSUE_NREGS];	// per-register countdown

	logic        hold_valid;
	instr_u      hold_instr;
	unit_class_e hold_class;
	reg_use_t    hold_use;
	logic        hold_illegal;

	logic                    busy_rd;
	logic                    busy_rs1;
	logic                    busy_rs2;
	logic                    hazard;
	logic                    issue;
	logic [`ISSUE_NREGS-1:0] reload;

	// x0 count is always zero so it never blocks
	assign busy_rd  = hold_use.rd  && (cnt[hold_instr.r_view.rd]  != '0);
	assign busy_rs1 = hold_use.rs1 && (cnt[hold_instr.r_view.rs1] != '0);
	assign busy_rs2 = hold_use.rs2 && (cnt[hold_instr.r_view.rs2] != '0);
	assign hazard   = busy_rd || busy_rs1 || busy_rs2;

	assign stall     = hold_valid && hazard;
	assign iss_valid = hold_valid && !hazard;
	assign issue     = iss_valid && iss_ready;
	assign sb_ready  = !hold_valid || issue;	// refill in the issue cycle

	assign iss_instr   = hold_instr;
	assign iss_class   = hold_class;
	assign iss_illegal = hold_illegal;

	// registers to reserve on this issue
	always_comb
	begin
		reload = '0;
		if (issue)
		begin
			if (hold_use.rd)
				reload[hold_instr.r_view.rd] = 1'b1;
			if (hold_use.rs1)
				reload[hold_instr.r_view.rs1] = 1'b1;
			if (hold_use.rs2)
				reload[hold_instr.r_view.rs2] = 1'b1;
		end
		reload[0] = 1'b0;	// x0 is hardwired
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `ISSUE_NREGS; i++)
				cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `ISSUE_NREGS; i++)
			begin
				if (reload[i])
					cnt[i] <= busy_load;
				else if (cnt[i] != '0)
					cnt[i] <= cnt[i] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
			hold_valid <= 1'b0;
		else if (sb_ready)
			hold_valid <= sb_valid;
	end

	always_ff @(posedge clk)
	begin
		if (sb_valid && sb_ready)
		begin
			hold_instr   <= sb_instr;
			hold_class   <= sb_class;
			hold_use     <= sb_use;
			hold_illegal <= sb_illegal;
		end
	end

	a_x0_free: assert property (@(posedge clk) disable iff (!nrst)
		cnt[0] == '0);

	// a stalled instruction is not issued and is still held next cycle
	a_stall_holds: assert property (@(posedge clk) disable iff (!nrst)
		stall |-> !issue ##1 hold_valid);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import issue_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic        dec_valid,
	input  instr_u      dec_instr,
	output logic        dec_ready,
	output logic        sb_valid,
	output instr_u      sb_instr,
	output unit_class_e sb_class,
	output reg_use_t    sb_use,
	output logic        sb_illegal,
	input  logic        sb_ready
);

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;

	unit_class_e dec_class;
	reg_use_t    dec_use;
	logic        dec_illegal;
	logic        i_type;
	logic        two_src;

	// class from the opcode
	always_comb
	begin
		dec_illegal = 1'b0;
		case (dec_instr.r_view.opcode)
			op_lui, op_auipc, op_jal: dec_class = uc_upper;
			op_jalr:                  dec_class = uc_jalr;
			op_branch:                dec_class = uc_branch;
			op_load:                  dec_class = uc_load;
			op_store:                 dec_class = uc_store;
			op_reg:                   dec_class = uc_alu_reg;
			op_imm:                   dec_class = uc_alu_imm;
			default:
			begin
				dec_class   = uc_none;
				dec_illegal = 1'b1;	// passes through, reserves nothing
			end
		endcase
	end

	// jalr, loads and addi read rd and rs1 only
	assign i_type = (dec_instr.i_view.opcode == op_jalr) ||
		(dec_instr.i_view.opcode == op_load) ||
		(dec_instr.i_view.opcode == op_imm);

	assign two_src = (dec_class == uc_branch) || (dec_class == uc_store) ||
		(dec_class == uc_alu_reg);

	always_comb
	begin
		dec_use.rd  = !dec_illegal && (dec_class != uc_branch);	// branches write nothing
		dec_use.rs1 = i_type || two_src;
		dec_use.rs2 = two_src;
	end

	assign dec_ready = !sb_valid || sb_ready;

	always_ff @(posedge clk)
	begin
		if (!nrst)
			sb_valid <= 1'b0;
		else if (dec_ready)
			sb_valid <= dec_valid;
	end

	// pipeline register, payload only
	always_ff @(posedge clk)
	begin
		if (dec_valid && dec_ready)
		begin
			sb_instr   <= dec_instr;
			sb_class   <= dec_class;
			sb_use     <= dec_use;
			sb_illegal <= dec_illegal;
		end
	end

endmodule

//--- verilog/ingress_stage.sv
`timescale 1ns/1ps

module ingress_stage import issue_pkg::*; (
	input  logic   clk,
	input  logic   nrst,
	input  logic   in_req,
	input  instr_u in_instr,
	output logic   in_ack,
	output logic   dec_valid,
	output instr_u dec_instr,
	input  logic   dec_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_ack,
		st_wait_drop
	} ing_state_e;

	ing_state_e state;
	logic       hold_free;
	logic       capture;

	assign hold_free = !dec_valid || dec_ready;	// slot empties this cycle
	assign capture   = (state == st_idle) && in_req && hold_free;
	assign in_ack    = (state != st_idle);

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			state     <= st_idle;
			dec_valid <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:      if (capture) state <= st_ack;
				st_ack:       state <= in_req ? st_wait_drop : st_idle;
				st_wait_drop: if (!in_req) state <= st_idle;	// release ack
				default:      state <= st_idle;
			endcase

			if (capture)
				dec_valid <= 1'b1;
			else if (dec_ready)
				dec_valid <= 1'b0;	// taken by decode
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			dec_instr <= in_instr;
	end

	// the source keeps req up until it sees ack
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
		$rose(in_ack) |-> in_req);

endmodule

//--- verilog/issue_pkg.sv
package issue_pkg;

	// R-type field layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	// I-type field layout
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	// one instruction word, two decodings
	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} instr_u;

	typedef enum logic [3:0] {
		uc_none    = 4'd0,	// unknown opcode
		uc_upper   = 4'd1,	// lui, auipc, jal
		uc_jalr    = 4'd2,
		uc_branch  = 4'd3,
		uc_load    = 4'd4,
		uc_store   = 4'd5,
		uc_alu_reg = 4'd6,
		uc_alu_imm = 4'd7
	} unit_class_e;

	// which register fields of the word are live
	typedef struct packed {
		logic rd;
		logic rs1;
		logic rs2;
	} reg_use_t;

endpackage

//--- verilog/issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// architectural register file size
`define ISSUE_NREGS 32

// cycles a register stays reserved after issue, legal range 1 to 15
`define ISSUE_BUSY_CYCLES 5

// countdown width, must hold ISSUE_BUSY_CYCLES
`define ISSUE_CNT_W 4

`endif
